// ==== hdl/spmm_cfg.svh ====
`ifndef SPMM_CFG_SVH
`define SPMM_CFG_SVH

// Columns of H, also the depth of each weight bank
`define SPMM_NUM_COLS    64
`define SPMM_COL_W       6

// Signed weight entries
`define SPMM_DATA_W      8

// Lane sum, wraps on overflow
`define SPMM_WH_W        12

// Row descriptor fields
`define SPMM_ROW_LEN_W   7
`define SPMM_NODE_W      8

// Rows that may be in flight between start and output
`define SPMM_INFO_DEPTH  4

`endif

// ==== hdl/spmm_pkg.sv ====
package spmm_pkg;

  `include "spmm_cfg.svh"

  // PE row tracking
  typedef enum logic {
    PE_IDLE = 1'b0,
    PE_ROW  = 1'b1
  } pe_state_e;

  // One output feature of WH
  typedef logic signed [`SPMM_WH_W-1:0] wh_sum_t;

  // Per-row side information carried to the output
  typedef struct packed {
    logic [`SPMM_NODE_W-1:0] num_node;
    logic                    src_flag;
  } row_info_t;

endpackage

// ==== hdl/weight_bank.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module weight_bank (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           we_i,
  input  logic [`SPMM_COL_W-1:0]         wr_addr_i,
  input  logic signed [`SPMM_DATA_W-1:0] wr_data_i,
  input  logic [`SPMM_COL_W-1:0]         rd_addr_i,
  output logic signed [`SPMM_DATA_W-1:0] rd_data_o
);

  // One column of W for this lane
  logic signed [`SPMM_DATA_W-1:0] mem [`SPMM_NUM_COLS];
  logic signed [`SPMM_DATA_W-1:0] rd_data_q;

  // Load port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read, data appears one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_q <= '0;
    end else begin
      rd_data_q <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

// ==== hdl/sp_pe.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module sp_pe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           row_start_i,
  input  logic                           spmm_vld_i,
  input  logic [`SPMM_ROW_LEN_W-1:0]     row_len_i,
  input  logic [`SPMM_COL_W-1:0]         col_idx_i,
  output logic [`SPMM_COL_W-1:0]         rd_addr_o,
  input  logic signed [`SPMM_DATA_W-1:0] rd_data_i,
  output spmm_pkg::wh_sum_t              sum_o,
  output logic                           sum_vld_o
);

  import spmm_pkg::*;

  localparam logic [`SPMM_ROW_LEN_W-1:0] LEN_ONE = `SPMM_ROW_LEN_W'(1);

  pe_state_e                  state_q;
  logic [`SPMM_ROW_LEN_W-1:0] remain_q;
  logic                       entry_vld;
  logic                       entry_first;
  logic                       entry_last;
  logic [1:0]                 vld_dly_q;
  logic [1:0]                 first_dly_q;
  logic [1:0]                 last_dly_q;
  logic [`SPMM_COL_W-1:0]     col_q;
  wh_sum_t                    wgt_ext;
  wh_sum_t                    acc_q;
  logic                       sum_vld_q;

  // Classify the current entry against the row boundaries
  always_comb begin
    entry_vld   = 1'b0;
    entry_first = 1'b0;
    entry_last  = 1'b0;
    if (spmm_vld_i) begin
      if (state_q == PE_IDLE) begin
        entry_vld   = row_start_i;
        entry_first = row_start_i;
        entry_last  = row_start_i && (row_len_i <= LEN_ONE);
      end else begin
        entry_vld   = 1'b1;
        entry_last  = (remain_q == LEN_ONE);
      end
    end
  end

  // remain_q counts the entries still to come in the open row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= PE_IDLE;
      remain_q <= '0;
    end else if (entry_vld) begin
      if (entry_last) begin
        state_q <= PE_IDLE;
      end else begin
        state_q <= PE_ROW;
      end
      remain_q <= entry_first ? (row_len_i - LEN_ONE) : (remain_q - LEN_ONE);
    end
  end

  // Two stages to meet the weight coming back from the bank
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_dly_q   <= '0;
      first_dly_q <= '0;
      last_dly_q  <= '0;
    end else begin
      vld_dly_q   <= {vld_dly_q[0], entry_vld};
      first_dly_q <= {first_dly_q[0], entry_first};
      last_dly_q  <= {last_dly_q[0], entry_last};
    end
  end

  // Bank address
  always_ff @(posedge clk) begin
    col_q <= col_idx_i;
  end

  assign rd_addr_o = col_q;

  // Sign extend the weight to the sum width
  assign wgt_ext = rd_data_i;

  // First entry restarts the sum, the rest add on
  always_ff @(posedge clk) begin
    if (vld_dly_q[1]) begin
      acc_q <= first_dly_q[1] ? wgt_ext : (acc_q + wgt_ext);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_vld_q <= 1'b0;
    end else begin
      sum_vld_q <= vld_dly_q[1] && last_dly_q[1];
    end
  end

  assign sum_o     = acc_q;
  assign sum_vld_o = sum_vld_q;

  // Upstream only streams entries inside a row that was started
  a_entry_in_row: assert property (@(posedge clk) disable iff (!rst_n)
    (spmm_vld_i && (state_q == PE_IDLE)) |-> row_start_i)
    else $error("sp_pe: entry outside a row");

endmodule

// ==== hdl/wh_row_assembler.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module wh_row_assembler (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       row_start_i,
  input  logic [`SPMM_NODE_W-1:0]    num_node_i,
  input  logic                       src_flag_i,
  input  spmm_pkg::wh_sum_t          sum0_i,
  input  spmm_pkg::wh_sum_t          sum1_i,
  input  logic                       sum_vld_i,
  output logic                       pe_rdy_o,
  output logic                       row_vld_o,
  output spmm_pkg::wh_sum_t          wh0_o,
  output spmm_pkg::wh_sum_t          wh1_o,
  output logic [`SPMM_NODE_W-1:0]    num_node_o,
  output logic                       src_flag_o
);

  import spmm_pkg::*;

  localparam int PTR_W = $clog2(`SPMM_INFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`SPMM_INFO_DEPTH);

  row_info_t              info_q [`SPMM_INFO_DEPTH];
  row_info_t              head_info;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push;
  logic                   pop;
  logic                   full;
  logic                   row_vld_q;
  wh_sum_t                wh0_q;
  wh_sum_t                wh1_q;
  row_info_t              out_info_q;

  assign push = row_start_i;
  assign pop  = sum_vld_i;
  assign full = (count_q == CNT_FULL);

  // Info entries wait here until both lanes finish the row
  always_ff @(posedge clk) begin
    if (push) begin
      info_q[wr_ptr_q] <= '{num_node: num_node_i, src_flag: src_flag_i};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_info = info_q[rd_ptr_q];

  // Output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_vld_q <= 1'b0;
    end else begin
      row_vld_q <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      wh0_q      <= sum0_i;
      wh1_q      <= sum1_i;
      out_info_q <= head_info;
    end
  end

  assign pe_rdy_o   = !full;
  assign row_vld_o  = row_vld_q;
  assign wh0_o      = wh0_q;
  assign wh1_o      = wh1_q;
  assign num_node_o = out_info_q.num_node;
  assign src_flag_o = out_info_q.src_flag;

  // Upstream has to respect pe_rdy_o
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full)
    else $error("wh_row_assembler: row started while queue full");

  // Every lane result must belong to a started row
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count_q != '0))
    else $error("wh_row_assembler: sum without row info");

endmodule

// ==== hdl/spmm_top.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module spmm_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           row_start_i,
  input  logic                           spmm_vld_i,
  input  logic [`SPMM_ROW_LEN_W-1:0]     row_len_i,
  input  logic [`SPMM_COL_W-1:0]         col_idx_i,
  input  logic [`SPMM_NODE_W-1:0]        num_node_i,
  input  logic                           src_flag_i,
  output logic                           pe_rdy_o,
  input  logic                           wgt_we_i,
  input  logic                           wgt_lane_i,
  input  logic [`SPMM_COL_W-1:0]         wgt_addr_i,
  input  logic signed [`SPMM_DATA_W-1:0] wgt_data_i,
  output logic                           row_vld_o,
  output spmm_pkg::wh_sum_t              wh0_o,
  output spmm_pkg::wh_sum_t              wh1_o,
  output logic [`SPMM_NODE_W-1:0]        num_node_o,
  output logic                           src_flag_o
);

  import spmm_pkg::*;

  logic [1:0]                     bank_we;
  logic [`SPMM_COL_W-1:0]         rd_addr [2];
  logic signed [`SPMM_DATA_W-1:0] rd_data [2];
  wh_sum_t                        lane_sum [2];
  logic [1:0]                     lane_sum_vld;

  // Lane select for weight loading
  assign bank_we[0] = wgt_we_i && !wgt_lane_i;
  assign bank_we[1] = wgt_we_i && wgt_lane_i;

  // One bank and one PE per output feature
  for (genvar g = 0; g < 2; g++) begin : g_lane
    weight_bank u_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .we_i      (bank_we[g]),
      .wr_addr_i (wgt_addr_i),
      .wr_data_i (wgt_data_i),
      .rd_addr_i (rd_addr[g]),
      .rd_data_o (rd_data[g])
    );

    sp_pe u_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .row_start_i (row_start_i),
      .spmm_vld_i  (spmm_vld_i),
      .row_len_i   (row_len_i),
      .col_idx_i   (col_idx_i),
      .rd_addr_o   (rd_addr[g]),
      .rd_data_i   (rd_data[g]),
      .sum_o       (lane_sum[g]),
      .sum_vld_o   (lane_sum_vld[g])
    );
  end

  wh_row_assembler u_asm (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_start_i (row_start_i),
    .num_node_i  (num_node_i),
    .src_flag_i  (src_flag_i),
    .sum0_i      (lane_sum[0]),
    .sum1_i      (lane_sum[1]),
    .sum_vld_i   (lane_sum_vld[0]),
    .pe_rdy_o    (pe_rdy_o),
    .row_vld_o   (row_vld_o),
    .wh0_o       (wh0_o),
    .wh1_o       (wh1_o),
    .num_node_o  (num_node_o),
    .src_flag_o  (src_flag_o)
  );

  // Both lanes see the same stream, so they finish rows together
  a_lanes_in_step: assert property (@(posedge clk) disable iff (!rst_n)
    lane_sum_vld[0] == lane_sum_vld[1])
    else $error("spmm_top: lane results out of step");

endmodule

// ==== bench/spmm_checker.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module spmm_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           row_start_i,
  input  logic                           spmm_vld_i,
  input  logic [`SPMM_ROW_LEN_W-1:0]     row_len_i,
  input  logic [`SPMM_COL_W-1:0]         col_idx_i,
  input  logic [`SPMM_NODE_W-1:0]        num_node_i,
  input  logic                           src_flag_i,
  input  logic                           wgt_we_i,
  input  logic                           wgt_lane_i,
  input  logic [`SPMM_COL_W-1:0]         wgt_addr_i,
  input  logic signed [`SPMM_DATA_W-1:0] wgt_data_i,
  input  logic                           pe_rdy_i,
  input  logic                           row_vld_i,
  input  spmm_pkg::wh_sum_t              wh0_i,
  input  spmm_pkg::wh_sum_t              wh1_i,
  input  logic [`SPMM_NODE_W-1:0]        out_node_i,
  input  logic                           out_flag_i,
  input  int                             test_id_i,
  input  logic                           test_end_i,
  output int                             err_cnt_o,
  output int                             row_cnt_o,
  output int                             pending_o,
  output int                             test_cnt_o
);

  import spmm_pkg::*;

  localparam int LATENCY = 4;

  // Expected WH row, with the cycle of its last entry
  typedef struct packed {
    wh_sum_t                 wh0;
    wh_sum_t                 wh1;
    logic [`SPMM_NODE_W-1:0] node;
    logic                    flag;
    logic [31:0]             cyc;
  } exp_row_t;

  logic signed [`SPMM_DATA_W-1:0] wgt0 [`SPMM_NUM_COLS];
  logic signed [`SPMM_DATA_W-1:0] wgt1 [`SPMM_NUM_COLS];
  exp_row_t                       exp_q [$];
  exp_row_t                       cur;
  logic                           in_row = 1'b0;
  logic                           rdy_check = 1'b0;
  int                             remain = 0;
  int                             acc0 = 0;
  int                             acc1 = 0;
  int                             cycle = 0;
  int                             errors = 0;
  int                             rows = 0;
  int                             tests = 0;
  int                             test_rows = 0;
  int                             test_errs = 0;

  function automatic string test_name(int id);
    case (id)
      0:       return "single_entry";
      1:       return "multi_entry";
      2:       return "back_to_back";
      3:       return "random_mix";
      4:       return "reset_reload";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_value(string what, logic signed [63:0] expv, logic signed [63:0] actv);
    $display("[ERROR] %s: %s expected %0d actual %0d",
             test_name(test_id_i), what, expv, actv);
    errors++;
    test_errs++;
  endtask

  task automatic report_problem(string what);
    $display("Check failed in %s: %s", test_name(test_id_i), what);
    errors++;
    test_errs++;
  endtask

  task automatic check_row();
    exp_row_t e;
    if (exp_q.size() == 0) begin
      report_problem("row_vld_o pulsed with no row in flight");
    end else begin
      e = exp_q.pop_front();
      rows++;
      test_rows++;
      if (wh0_i !== e.wh0) report_value("wh0_o", e.wh0, wh0_i);
      if (wh1_i !== e.wh1) report_value("wh1_o", e.wh1, wh1_i);
      if (out_node_i !== e.node) report_value("num_node_o", e.node, out_node_i);
      if (out_flag_i !== e.flag) report_value("src_flag_o", e.flag, out_flag_i);
      if (cycle - int'(e.cyc) != LATENCY) begin
        report_value("row latency", LATENCY, cycle - int'(e.cyc));
      end
    end
  endtask

  // Reference rows built from the stream and the loaded weights
  task automatic track_input();
    if (wgt_we_i) begin
      if (wgt_lane_i) wgt1[wgt_addr_i] = wgt_data_i;
      else wgt0[wgt_addr_i] = wgt_data_i;
    end
    if (spmm_vld_i) begin
      if (!in_row && row_start_i) begin
        in_row   = 1'b1;
        remain   = int'(row_len_i);
        acc0     = 0;
        acc1     = 0;
        cur.node = num_node_i;
        cur.flag = src_flag_i;
      end
      if (in_row) begin
        acc0 += int'(wgt0[col_idx_i]);
        acc1 += int'(wgt1[col_idx_i]);
        remain--;
        // Sums wrap at the WH width
        if (remain <= 0) begin
          cur.wh0 = acc0[`SPMM_WH_W-1:0];
          cur.wh1 = acc1[`SPMM_WH_W-1:0];
          cur.cyc = cycle;
          exp_q.push_back(cur);
          in_row = 1'b0;
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      in_row    = 1'b0;
      rdy_check = 1'b1;
    end else begin
      if (rdy_check) begin
        rdy_check = 1'b0;
        if (pe_rdy_i !== 1'b1) report_value("pe_rdy_o after reset", 1, pe_rdy_i);
      end
      if (row_vld_i === 1'b1) check_row();
      else if (row_vld_i !== 1'b0) report_problem("row_vld_o is unknown");
      track_input();
    end
    if (test_end_i) begin
      tests++;
      $display("[TEST] %-14s %s  rows %0d  errors %0d", test_name(test_id_i),
               (test_errs == 0) ? "pass" : "fail", test_rows, test_errs);
      test_rows = 0;
      test_errs = 0;
    end
    cycle++;
  end

  assign err_cnt_o  = errors;
  assign row_cnt_o  = rows;
  assign pending_o  = exp_q.size();
  assign test_cnt_o = tests;

endmodule

// ==== bench/tb_spmm.sv ====
`timescale 1ns/100ps
`include "spmm_cfg.svh"

module tb_spmm;

  import spmm_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic                           clk = 1'b0;
  logic                           rst_n = 1'b0;
  logic                           row_start = 1'b0;
  logic                           spmm_vld = 1'b0;
  logic [`SPMM_ROW_LEN_W-1:0]     row_len = '0;
  logic [`SPMM_COL_W-1:0]         col_idx = '0;
  logic [`SPMM_NODE_W-1:0]        num_node = '0;
  logic                           src_flag = 1'b0;
  logic                           wgt_we = 1'b0;
  logic                           wgt_lane = 1'b0;
  logic [`SPMM_COL_W-1:0]         wgt_addr = '0;
  logic signed [`SPMM_DATA_W-1:0] wgt_data = '0;
  logic                           pe_rdy;
  logic                           row_vld;
  wh_sum_t                        wh0;
  wh_sum_t                        wh1;
  logic [`SPMM_NODE_W-1:0]        out_node;
  logic                           out_flag;
  int                             test_id = 0;
  logic                           test_end = 1'b0;
  int                             err_cnt;
  int                             row_cnt;
  int                             pending;
  int                             test_cnt;
  int                             seed = 32'h109c;

  always #2 clk = ~clk;

  spmm_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_start_i (row_start),
    .spmm_vld_i  (spmm_vld),
    .row_len_i   (row_len),
    .col_idx_i   (col_idx),
    .num_node_i  (num_node),
    .src_flag_i  (src_flag),
    .pe_rdy_o    (pe_rdy),
    .wgt_we_i    (wgt_we),
    .wgt_lane_i  (wgt_lane),
    .wgt_addr_i  (wgt_addr),
    .wgt_data_i  (wgt_data),
    .row_vld_o   (row_vld),
    .wh0_o       (wh0),
    .wh1_o       (wh1),
    .num_node_o  (out_node),
    .src_flag_o  (out_flag)
  );

  spmm_checker u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_start_i (row_start),
    .spmm_vld_i  (spmm_vld),
    .row_len_i   (row_len),
    .col_idx_i   (col_idx),
    .num_node_i  (num_node),
    .src_flag_i  (src_flag),
    .wgt_we_i    (wgt_we),
    .wgt_lane_i  (wgt_lane),
    .wgt_addr_i  (wgt_addr),
    .wgt_data_i  (wgt_data),
    .pe_rdy_i    (pe_rdy),
    .row_vld_i   (row_vld),
    .wh0_i       (wh0),
    .wh1_i       (wh1),
    .out_node_i  (out_node),
    .out_flag_i  (out_flag),
    .test_id_i   (test_id),
    .test_end_i  (test_end),
    .err_cnt_o   (err_cnt),
    .row_cnt_o   (row_cnt),
    .pending_o   (pending),
    .test_cnt_o  (test_cnt)
  );

  // Next drive point, 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  task automatic fail_timeout(string what);
    $display("Timeout: %s", what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) step();
    rst_n = 1'b1;
  endtask

  task automatic write_weight(logic lane, int addr, int data);
    wgt_we   = 1'b1;
    wgt_lane = lane;
    wgt_addr = addr[`SPMM_COL_W-1:0];
    wgt_data = data[`SPMM_DATA_W-1:0];
    step();
    wgt_we = 1'b0;
  endtask

  task automatic load_lane(logic lane);
    for (int a = 0; a < `SPMM_NUM_COLS; a++) begin
      write_weight(lane, a, $random(seed));
    end
  endtask

  task automatic wait_ready();
    int n = 0;
    while (pe_rdy !== 1'b1) begin
      if (n >= WAIT_LIMIT) fail_timeout("pe_rdy_o stayed low");
      step();
      n++;
    end
  endtask

  // Columns are limited by col_mask so that small masks repeat columns
  task automatic send_row(int len, logic [`SPMM_COL_W-1:0] col_mask);
    logic [31:0] r;
    wait_ready();
    for (int i = 0; i < len; i++) begin
      r         = $random(seed);
      row_start = (i == 0);
      spmm_vld  = 1'b1;
      row_len   = len[`SPMM_ROW_LEN_W-1:0];
      col_idx   = r[`SPMM_COL_W-1:0] & col_mask;
      if (i == 0) begin
        num_node = r[15:8];
        src_flag = r[16];
      end
      step();
    end
    row_start = 1'b0;
    spmm_vld  = 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) step();
  endtask

  task automatic finish_test();
    int n = 0;
    while (pending != 0) begin
      if (n >= WAIT_LIMIT) fail_timeout("expected rows never left the DUT");
      step();
      n++;
    end
    idle(3);
    test_end = 1'b1;
    step();
    test_end = 1'b0;
  endtask

  initial begin
    apply_reset();
    load_lane(1'b0);
    load_lane(1'b1);
    idle(2);

    test_id = 0;
    repeat (16) begin
      send_row(1, 6'h3f);
      idle(rand_range(0, 3));
    end
    finish_test();

    // Long row on one column drives both sums past the wrap
    test_id = 1;
    write_weight(1'b0, 0, 127);
    write_weight(1'b1, 0, -128);
    idle(1);
    send_row(40, 6'h00);
    repeat (16) begin
      send_row(rand_range(2, 8), 6'h07);
      idle(rand_range(0, 3));
    end
    finish_test();

    test_id = 2;
    repeat (24) send_row(rand_range(1, 8), 6'h3f);
    finish_test();

    test_id = 3;
    repeat (24) begin
      send_row(rand_range(1, 8), 6'h3f);
      idle(rand_range(0, 2));
    end
    finish_test();

    // Second reset while idle, then fresh weights in both banks
    test_id = 4;
    apply_reset();
    idle(10);
    load_lane(1'b0);
    load_lane(1'b1);
    idle(2);
    repeat (12) begin
      send_row(rand_range(1, 8), 6'h3f);
      idle(rand_range(0, 2));
    end
    finish_test();

    $display("Done: %0d tests, %0d rows checked, %0d errors", test_cnt, row_cnt, err_cnt);
    if (err_cnt == 0 && row_cnt > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/spmm_pkg.sv
hdl/weight_bank.sv
hdl/sp_pe.sv
hdl/wh_row_assembler.sv
hdl/spmm_top.sv
bench/spmm_checker.sv
bench/tb_spmm.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spmm
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
